/* common/bp_pkg.sv */
/*
 * Branch prediction shared definitions.
 * Address type, the two-way decode of a fetch address, the control
 * transfer kinds and the fixed table geometry.
 */
package bp_pkg;

	// One fetch or target address
	typedef logic [31:0] address_t;

	// ==============================
	// Table geometry
	// ==============================

	// Address bits feeding the gselect index, above the halfword offset
	localparam int pc_idx_bits = 7;
	// BTB index and tag widths, tied to the union layout below
	localparam int btb_index_bits = 6;
	localparam int btb_tag_bits = 24;
	// Sequential fetch step in bytes
	localparam int unsigned inst_bytes = 4;

	// The same fetch address seen by the BTB and by the gselect table
	typedef union packed {
		struct packed {
			logic [btb_tag_bits-1:0] tag;
			logic [btb_index_bits-1:0] index;
			logic [1:0] offset;
		} btb;
		struct packed {
			logic [31-pc_idx_bits-1:0] unused;
			logic [pc_idx_bits-1:0] index;
			logic offset;
		} gsel;
		address_t word;
	} fetch_addr_u;

	// Kind of control transfer recorded in the BTB
	typedef enum logic [1:0] {
		xk_branch = 2'd0,
		xk_jump   = 2'd1,
		xk_call   = 2'd2,
		xk_return = 2'd3
	} xfer_kind_e;

endpackage

/* files.f */
+incdir+verif
common/bp_pkg.sv
rtl/gselect/gselect_predictor.sv
rtl/btb/branch_target_buffer.sv
rtl/return_stack.sv
rtl/next_pc_select.sv
rtl/branch_predict_unit.sv
verif/tb_branch_predict_unit.sv

/* rtl/branch_predict_unit.sv */
/*
 * Branch prediction unit, fetch stage.
 * Joins the gselect predictor, BTB and return stack to produce the
 * next fetch address in the same cycle, learning from the commit port.
 */
`timescale 1ns/1ps

module branch_predict_unit #(
	parameter int hist_len = 2,
	parameter int btb_entries = 64,
	parameter int ras_depth = 8
) (
	input  logic clk,
	input  logic rst,
	input  logic en,
	input  bp_pkg::address_t fetch_pc,
	input  logic cmt_valid,
	input  bp_pkg::address_t cmt_pc,
	input  bp_pkg::xfer_kind_e cmt_kind,
	input  logic cmt_taken,
	input  bp_pkg::address_t cmt_target,
	output bp_pkg::address_t next_pc,
	output logic predict_taken
);
	import bp_pkg::*;

	logic cmt_branch;
	logic pred_taken;
	logic btb_hit;
	xfer_kind_e btb_kind;
	address_t btb_target;
	address_t ras_top;
	logic ras_push;
	logic ras_pop;

	// Only conditional branches train the direction counters
	assign cmt_branch = (cmt_kind == xk_branch);

	gselect_predictor #(.hist_len(hist_len)) u_gselect (
		.clk(clk), .rst(rst), .en(en),
		.fetch_pc(fetch_pc),
		.cmt_valid(cmt_valid), .cmt_branch(cmt_branch),
		.cmt_pc(cmt_pc), .cmt_taken(cmt_taken),
		.pred_taken(pred_taken)
	);

	branch_target_buffer #(.btb_entries(btb_entries)) u_btb (
		.clk(clk), .rst(rst), .en(en),
		.fetch_pc(fetch_pc),
		.cmt_valid(cmt_valid), .cmt_pc(cmt_pc), .cmt_kind(cmt_kind),
		.cmt_taken(cmt_taken), .cmt_target(cmt_target),
		.btb_hit(btb_hit), .btb_kind(btb_kind), .btb_target(btb_target)
	);

	return_stack #(.ras_depth(ras_depth)) u_ras (
		.clk(clk), .rst(rst),
		.fetch_pc(fetch_pc),
		.ras_push(ras_push), .ras_pop(ras_pop),
		.ras_top(ras_top)
	);

	next_pc_select u_select (
		.en(en), .fetch_pc(fetch_pc),
		.pred_taken(pred_taken), .btb_hit(btb_hit),
		.btb_kind(btb_kind), .btb_target(btb_target), .ras_top(ras_top),
		.next_pc(next_pc), .predict_taken(predict_taken),
		.ras_push(ras_push), .ras_pop(ras_pop)
	);

	// BTB size is fixed by the index field of the address union
	assert property (@(posedge clk) btb_entries == (1 << btb_index_bits));

endmodule

/* rtl/btb/branch_target_buffer.sv */
/*
 * Branch target buffer.
 * Direct-mapped table of tag, target and transfer kind, looked up by
 * fetch address and written by taken commits.
 */
`timescale 1ns/1ps

module branch_target_buffer #(
	parameter int btb_entries = 64
) (
	input  logic clk,
	input  logic rst,
	input  logic en,
	input  bp_pkg::address_t fetch_pc,
	input  logic cmt_valid,
	input  bp_pkg::address_t cmt_pc,
	input  bp_pkg::xfer_kind_e cmt_kind,
	input  logic cmt_taken,
	input  bp_pkg::address_t cmt_target,
	output logic btb_hit,
	output bp_pkg::xfer_kind_e btb_kind,
	output bp_pkg::address_t btb_target
);
	import bp_pkg::*;

	// ==============================
	// Storage
	// ==============================

	// Payload arrays carry no reset, only the valid bits are cleared
	logic [btb_tag_bits-1:0] tag_table [btb_entries];
	xfer_kind_e kind_table [btb_entries];
	address_t target_table [btb_entries];
	logic [btb_entries-1:0] entry_valid;

	fetch_addr_u fetch_view;
	fetch_addr_u cmt_view;
	logic [btb_index_bits-1:0] rd_idx;
	logic [btb_index_bits-1:0] wr_idx;
	logic tag_match;
	logic wr_en;

	assign fetch_view.word = fetch_pc;
	assign cmt_view.word = cmt_pc;

	// ==============================
	// Fetch lookup
	// ==============================

	assign rd_idx = fetch_view.btb.index;
	assign tag_match = (tag_table[rd_idx] == fetch_view.btb.tag);
	// A hit needs a valid entry with the same tag, and prediction enabled
	assign btb_hit = en & entry_valid[rd_idx] & tag_match;
	// Kind and target are only meaningful together with btb_hit
	assign btb_kind = kind_table[rd_idx];
	assign btb_target = target_table[rd_idx];

	// ==============================
	// Commit write
	// ==============================

	assign wr_idx = cmt_view.btb.index;
	// Any taken transfer allocates or refreshes its slot
	assign wr_en = en & cmt_valid & cmt_taken;

	always_ff @(posedge clk) begin
		if (rst) begin
			entry_valid <= '0;
		end else if (wr_en) begin
			entry_valid[wr_idx] <= 1'b1;
		end
	end

	// Overwrite the whole entry, a conflicting address simply evicts it
	always_ff @(posedge clk) begin
		if (wr_en) begin
			tag_table[wr_idx] <= cmt_view.btb.tag;
			kind_table[wr_idx] <= cmt_kind;
			target_table[wr_idx] <= cmt_target;
		end
	end

endmodule

/* rtl/gselect/gselect_predictor.sv */
/*
 * Gselect direction predictor.
 * Two-bit counters indexed by fetch address bits joined with global
 * history, trained from committed conditional branches.
 */
`timescale 1ns/1ps

module gselect_predictor #(
	parameter int hist_len = 2
) (
	input  logic clk,
	input  logic rst,
	input  logic en,
	input  bp_pkg::address_t fetch_pc,
	input  logic cmt_valid,
	input  logic cmt_branch,
	input  bp_pkg::address_t cmt_pc,
	input  logic cmt_taken,
	output logic pred_taken
);
	import bp_pkg::*;

	localparam int idx_bits = pc_idx_bits + hist_len;
	localparam int entries = 1 << idx_bits;

	// Counter storage, 0 is strongly not taken and 3 strongly taken
	logic [1:0] ctr_table [entries];
	logic [entries-1:0] ctr_valid;
	logic [hist_len-1:0] ghist;

	fetch_addr_u fetch_view;
	fetch_addr_u cmt_view;
	logic [idx_bits-1:0] rd_idx;
	logic [idx_bits-1:0] wr_idx;
	logic [1:0] rd_ctr;
	logic [1:0] wr_ctr_old;
	logic [1:0] wr_ctr_new;
	logic train;

	assign fetch_view.word = fetch_pc;
	assign cmt_view.word = cmt_pc;

	// ==============================
	// Fetch side lookup
	// ==============================

	// Read index follows the current history
	assign rd_idx = {fetch_view.gsel.index, ghist};
	// An entry never trained reads as weakly not taken
	assign rd_ctr = ctr_valid[rd_idx] ? ctr_table[rd_idx] : 2'd1;
	assign pred_taken = en & rd_ctr[1];

	// ==============================
	// Commit side training
	// ==============================

	assign train = en & cmt_valid & cmt_branch;
	// Write index uses the history as it stood before this commit shifts it
	assign wr_idx = {cmt_view.gsel.index, ghist};
	assign wr_ctr_old = ctr_valid[wr_idx] ? ctr_table[wr_idx] : 2'd1;

	// Step one toward the outcome, saturating at both ends
	always_comb begin
		if (cmt_taken) begin
			wr_ctr_new = (wr_ctr_old == 2'd3) ? 2'd3 : wr_ctr_old + 2'd1;
		end else begin
			wr_ctr_new = (wr_ctr_old == 2'd0) ? 2'd0 : wr_ctr_old - 2'd1;
		end
	end

	// History and valid bits are control state
	always_ff @(posedge clk) begin
		if (rst) begin
			ghist <= '0;
			ctr_valid <= '0;
		end else if (train) begin
			// Newest outcome enters at bit 0, the oldest falls off the top
			ghist <= hist_len'({ghist, cmt_taken});
			ctr_valid[wr_idx] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (train) begin
			ctr_table[wr_idx] <= wr_ctr_new;
		end
	end

	// A commit must carry a known outcome or the history goes bad
	assert property (@(posedge clk) disable iff (rst) cmt_valid |-> !$isunknown(cmt_taken));

endmodule

/* rtl/next_pc_select.sv */
/*
 * Next fetch address selection.
 * Picks sequential, BTB or return stack address and raises the stack
 * requests for predicted calls and returns.
 */
`timescale 1ns/1ps

module next_pc_select (
	input  logic en,
	input  bp_pkg::address_t fetch_pc,
	input  logic pred_taken,
	input  logic btb_hit,
	input  bp_pkg::xfer_kind_e btb_kind,
	input  bp_pkg::address_t btb_target,
	input  bp_pkg::address_t ras_top,
	output bp_pkg::address_t next_pc,
	output logic predict_taken,
	output logic ras_push,
	output logic ras_pop
);
	import bp_pkg::*;

	address_t seq_pc;

	assign seq_pc = fetch_pc + address_t'(inst_bytes);

	always_comb begin
		next_pc = seq_pc;
		ras_push = 1'b0;
		ras_pop = 1'b0;
		// Without a hit the fetch simply falls through
		if (en && btb_hit) begin
			case (btb_kind)
				xk_jump: next_pc = btb_target;
				xk_call: begin
					next_pc = btb_target;
					ras_push = 1'b1;
				end
				xk_return: begin
					next_pc = ras_top;
					ras_pop = 1'b1;
				end
				// Conditional branch goes by the direction predictor
				default: begin
					if (pred_taken) begin
						next_pc = btb_target;
					end
				end
			endcase
		end
	end

	// Taken means leaving the sequential path
	assign predict_taken = (next_pc != seq_pc);

endmodule

/* rtl/return_stack.sv */
/*
 * Return address stack.
 * Circular stack of return addresses, pushed on predicted calls and
 * popped on predicted returns.
 */
`timescale 1ns/1ps

module return_stack #(
	parameter int ras_depth = 8
) (
	input  logic clk,
	input  logic rst,
	input  bp_pkg::address_t fetch_pc,
	input  logic ras_push,
	input  logic ras_pop,
	output bp_pkg::address_t ras_top
);
	import bp_pkg::*;

	localparam int ptr_bits = (ras_depth > 1) ? $clog2(ras_depth) : 1;
	localparam int cnt_bits = $clog2(ras_depth + 1);

	address_t stack_mem [ras_depth];
	// ptr points at the current top, count tracks how many entries hold data
	logic [ptr_bits-1:0] ptr;
	logic [ptr_bits-1:0] ptr_inc;
	logic [ptr_bits-1:0] ptr_dec;
	logic [cnt_bits-1:0] count;
	logic empty;

	assign empty = (count == '0);

	// Wrap explicitly so a depth that is not a power of two still works
	assign ptr_inc = (ptr == ptr_bits'(ras_depth - 1)) ? '0 : ptr + 1'b1;
	assign ptr_dec = (ptr == '0) ? ptr_bits'(ras_depth - 1) : ptr - 1'b1;

	// An empty stack reads zero
	assign ras_top = empty ? '0 : stack_mem[ptr];

	always_ff @(posedge clk) begin
		if (rst) begin
			ptr <= '0;
			count <= '0;
		end else if (ras_push) begin
			ptr <= ptr_inc;
			// Once full the oldest entry is overwritten and count stays put
			if (count != cnt_bits'(ras_depth)) begin
				count <= count + 1'b1;
			end
		end else if (ras_pop && !empty) begin
			ptr <= ptr_dec;
			count <= count - 1'b1;
		end
	end

	// The return address is the instruction after the call
	always_ff @(posedge clk) begin
		if (ras_push) begin
			stack_mem[ptr_inc] <= fetch_pc + address_t'(inst_bytes);
		end
	end

	// One fetch is either a call or a return, never both
	assert property (@(posedge clk) disable iff (rst) !(ras_push && ras_pop));

endmodule

/* verif/bp_model.svh */
/*
 * Reference model of the branch prediction unit.
 * Counters, history, BTB and return stack kept as plain arrays and
 * updated by the testbench once per clock edge.
 */
`ifndef BP_MODEL_SVH
`define BP_MODEL_SVH

localparam int gsel_entries = 1 << (pc_idx_bits + hist_len);

logic [1:0] m_ctr [gsel_entries];
bit m_ctr_valid [gsel_entries];
logic [hist_len-1:0] m_hist;
bit m_btb_valid [btb_entries];
logic [23:0] m_btb_tag [btb_entries];
xfer_kind_e m_btb_kind [btb_entries];
address_t m_btb_target [btb_entries];
// Oldest return address at the front, top of stack at the back
address_t m_ras [$];

function automatic void model_reset();
	for (int i = 0; i < gsel_entries; i++) begin
		m_ctr_valid[i] = 1'b0;
		m_ctr[i] = 2'd1;
	end
	for (int i = 0; i < btb_entries; i++) begin
		m_btb_valid[i] = 1'b0;
	end
	m_hist = '0;
	m_ras.delete();
endfunction

// Counter for one gselect slot, untrained slots are weakly not taken
function automatic logic [1:0] model_counter(input int idx);
	return m_ctr_valid[idx] ? m_ctr[idx] : 2'd1;
endfunction

function automatic address_t model_ras_top();
	return (m_ras.size() == 0) ? 32'h0 : m_ras[m_ras.size()-1];
endfunction

// Expected fetch response plus the stack request it causes
function automatic void model_predict(input logic e, input address_t pc,
		output address_t nxt, output logic tkn, output logic push, output logic pop);
	int bi;
	int gi;
	address_t seq;
	bi = int'(pc[7:2]);
	gi = int'({pc[7:1], m_hist});
	seq = pc + 32'd4;
	nxt = seq;
	push = 1'b0;
	pop = 1'b0;
	if (e && m_btb_valid[bi] && m_btb_tag[bi] == pc[31:8]) begin
		case (m_btb_kind[bi])
			xk_jump: nxt = m_btb_target[bi];
			xk_call: begin
				nxt = m_btb_target[bi];
				push = 1'b1;
			end
			xk_return: begin
				nxt = model_ras_top();
				pop = 1'b1;
			end
			default: begin
				if (model_counter(gi) >= 2'd2) begin
					nxt = m_btb_target[bi];
				end
			end
		endcase
	end
	tkn = (nxt != seq);
endfunction

// One commit at a clock edge, ignored while disabled
function automatic void model_commit(input logic e, input logic v, input address_t pc,
		input xfer_kind_e k, input logic t, input address_t tgt);
	int bi;
	int gi;
	logic [1:0] c;
	if (e && v) begin
		if (k == xk_branch) begin
			// Index is formed with the history before the shift
			gi = int'({pc[7:1], m_hist});
			c = model_counter(gi);
			if (t && c != 2'd3) begin
				c = c + 2'd1;
			end else if (!t && c != 2'd0) begin
				c = c - 2'd1;
			end
			m_ctr[gi] = c;
			m_ctr_valid[gi] = 1'b1;
			m_hist = (m_hist << 1) | hist_len'(t);
		end
		if (t) begin
			bi = int'(pc[7:2]);
			m_btb_valid[bi] = 1'b1;
			m_btb_tag[bi] = pc[31:8];
			m_btb_kind[bi] = k;
			m_btb_target[bi] = tgt;
		end
	end
endfunction

function automatic void model_stack(input logic push, input logic pop, input address_t pc);
	if (push) begin
		m_ras.push_back(pc + 32'd4);
		// A full stack loses its oldest entry
		if (m_ras.size() > ras_depth) begin
			void'(m_ras.pop_front());
		end
	end else if (pop && m_ras.size() != 0) begin
		void'(m_ras.pop_back());
	end
endfunction

`endif

/* verif/tb_branch_predict_unit.sv */
/*
 * Testbench for the branch prediction unit.
 * Directed tests and an LCG driven sequence checked against a model.
 */
`timescale 1ns/1ps

module tb_branch_predict_unit;
	import bp_pkg::*;

	localparam int hist_len = 2;
	localparam int btb_entries = 64;
	localparam int ras_depth = 8;
	localparam int clk_period = 40;
	localparam int random_steps = 150;
	// Cycle budget of each phase, the watchdog allows twice the sum
	localparam int total_cycles = 4 + 8 + 6 + 24 + 10 + 10 + random_steps;
	localparam int watchdog_ns = total_cycles * 2 * clk_period;
	// Fetch address that never sits in the BTB
	localparam address_t idle_pc = 32'hffff_0000;

	logic clk;
	logic rst;
	logic en;
	address_t fetch_pc;
	logic cmt_valid;
	address_t cmt_pc;
	xfer_kind_e cmt_kind;
	logic cmt_taken;
	address_t cmt_target;
	address_t next_pc;
	logic predict_taken;

	int err_count;
	int check_count;
	int test_count;
	logic [31:0] lcg_state;

	`include "bp_model.svh"

	branch_predict_unit #(
		.hist_len(hist_len),
		.btb_entries(btb_entries),
		.ras_depth(ras_depth)
	) UUT (
		.clk(clk), .rst(rst), .en(en),
		.fetch_pc(fetch_pc),
		.cmt_valid(cmt_valid), .cmt_pc(cmt_pc), .cmt_kind(cmt_kind),
		.cmt_taken(cmt_taken), .cmt_target(cmt_target),
		.next_pc(next_pc), .predict_taken(predict_taken)
	);

	always #(clk_period / 2) clk = ~clk;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic check_address(input string name, input address_t actual, input address_t expected);
		check_count++;
		if (actual !== expected) begin
			err_count++;
			$display("error at %0t: %s is %h, expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic check_bit(input string name, input logic actual, input logic expected);
		check_count++;
		if (actual !== expected) begin
			err_count++;
			$display("error at %0t: %s is %b, expected %b", $time, name, actual, expected);
		end
	endtask

	// ==============================
	// Cycle driver
	// ==============================

	// Drive one cycle, check the fetch response mid cycle, then advance the model
	task automatic drive_cycle(input logic e, input address_t fpc, input logic cv,
			input address_t cpc, input xfer_kind_e ck, input logic ct, input address_t ctgt);
		address_t exp_next;
		logic exp_taken;
		logic exp_push;
		logic exp_pop;
		@(posedge clk);
		#2;
		en = e;
		fetch_pc = fpc;
		cmt_valid = cv;
		cmt_pc = cpc;
		cmt_kind = ck;
		cmt_taken = ct;
		cmt_target = ctgt;
		@(negedge clk);
		model_predict(e, fpc, exp_next, exp_taken, exp_push, exp_pop);
		check_address("next_pc", next_pc, exp_next);
		check_bit("predict_taken", predict_taken, exp_taken);
		// Both take effect at the coming rising edge
		model_commit(e, cv, cpc, ck, ct, ctgt);
		model_stack(exp_push, exp_pop, fpc);
	endtask

	task automatic fetch_at(input logic e, input address_t fpc);
		drive_cycle(e, fpc, 1'b0, idle_pc, xk_branch, 1'b0, 32'h0);
	endtask

	task automatic commit_at(input logic e, input address_t cpc, input xfer_kind_e ck,
			input logic ct, input address_t ctgt);
		drive_cycle(e, idle_pc, 1'b1, cpc, ck, ct, ctgt);
	endtask

	task automatic report_test(input string name, input int errs_before);
		test_count++;
		$display("test %s finished with %0d errors", name, err_count - errs_before);
	endtask

	// ==============================
	// Directed tests
	// ==============================

	task automatic test_reset_state();
		int e0;
		e0 = err_count;
		fetch_at(1'b1, 32'h0000_0000);
		fetch_at(1'b1, 32'h0000_1000);
		fetch_at(1'b1, 32'h8000_0040);
		fetch_at(1'b1, 32'hffff_fffc);
		fetch_at(1'b1, idle_pc);
		report_test("reset_state", e0);
	endtask

	task automatic test_jump_alloc();
		int e0;
		e0 = err_count;
		commit_at(1'b1, 32'h0000_1040, xk_jump, 1'b1, 32'h0000_2000);
		fetch_at(1'b1, 32'h0000_1040);
		// Same index, other tag, must miss
		fetch_at(1'b1, 32'h0001_1040);
		report_test("jump_alloc", e0);
	endtask

	task automatic test_gselect_history();
		int e0;
		e0 = err_count;
		// Another taken branch fills the history with ones first
		commit_at(1'b1, 32'h0000_3200, xk_branch, 1'b1, 32'h0000_3300);
		commit_at(1'b1, 32'h0000_3200, xk_branch, 1'b1, 32'h0000_3300);
		commit_at(1'b1, 32'h0000_3010, xk_branch, 1'b1, 32'h0000_3100);
		commit_at(1'b1, 32'h0000_3010, xk_branch, 1'b1, 32'h0000_3100);
		fetch_at(1'b1, 32'h0000_3010);
		// Alternating outcomes walk the history through other slots
		for (int i = 0; i < 8; i++) begin
			commit_at(1'b1, 32'h0000_3010, xk_branch, i[0], 32'h0000_3100);
			fetch_at(1'b1, 32'h0000_3010);
		end
		report_test("gselect_history", e0);
	endtask

	task automatic test_call_return();
		int e0;
		e0 = err_count;
		commit_at(1'b1, 32'h0000_4020, xk_call, 1'b1, 32'h0000_5000);
		commit_at(1'b1, 32'h0000_5030, xk_return, 1'b1, 32'h0000_4024);
		fetch_at(1'b1, 32'h0000_4020);
		fetch_at(1'b1, 32'h0000_5030);
		// Nested calls, then a return on an empty stack
		fetch_at(1'b1, 32'h0000_4020);
		fetch_at(1'b1, 32'h0000_4020);
		fetch_at(1'b1, 32'h0000_5030);
		fetch_at(1'b1, 32'h0000_5030);
		fetch_at(1'b1, 32'h0000_5030);
		report_test("call_return", e0);
	endtask

	task automatic test_enable_low();
		int e0;
		e0 = err_count;
		fetch_at(1'b0, 32'h0000_1040);
		fetch_at(1'b0, 32'h0000_4020);
		commit_at(1'b0, 32'h0000_1040, xk_jump, 1'b1, 32'h0000_6000);
		commit_at(1'b0, 32'h0000_7000, xk_jump, 1'b1, 32'h0000_7400);
		commit_at(1'b0, 32'h0000_3010, xk_branch, 1'b0, 32'h0000_3100);
		fetch_at(1'b1, 32'h0000_1040);
		fetch_at(1'b1, 32'h0000_7000);
		fetch_at(1'b1, 32'h0000_3010);
		report_test("enable_low", e0);
	endtask

	task automatic test_random_mix();
		int e0;
		logic [31:0] r1;
		logic [31:0] r2;
		logic [31:0] r3;
		e0 = err_count;
		for (int i = 0; i < random_steps; i++) begin
			r1 = lcg_next();
			r2 = lcg_next();
			r3 = lcg_next();
			// Small address pool so that hits and evictions both happen
			drive_cycle(r3[30:28] != 3'd0,
				32'h0001_0000 | ((r1 >> 8) & 32'h1fc),
				r1[28],
				32'h0001_0000 | ((r2 >> 8) & 32'h1fc),
				xfer_kind_e'(r2[25:24]),
				r2[29],
				32'h0001_0000 | ((r3 >> 8) & 32'hfffc));
		end
		report_test("random_mix", e0);
	endtask

	// ==============================
	// Sequence and watchdog
	// ==============================

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		en = 1'b0;
		fetch_pc = idle_pc;
		cmt_valid = 1'b0;
		cmt_pc = '0;
		cmt_kind = xk_branch;
		cmt_taken = 1'b0;
		cmt_target = '0;
		err_count = 0;
		check_count = 0;
		test_count = 0;
		lcg_state = 32'hb74e_d496;
		model_reset();
		repeat (4) @(posedge clk);
		#2;
		rst = 1'b0;
		test_reset_state();
		test_jump_alloc();
		test_gselect_history();
		test_call_return();
		test_enable_low();
		test_random_mix();
		$display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
		if (err_count == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	initial begin
		#(watchdog_ns);
		$display("timeout: the tests did not finish within %0d ns", watchdog_ns);
		$display("Result: FAILED");
		$finish;
	end

endmodule
